// ==== ctrl_fsm.sv ====
// control sequencer
// state register with stall hold, next-state logic,
// memory access kind and the decode-time trap request
module ctrl_fsm (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   stall,
  input  ctrl_pkg::instr_class_t cls,
  input  logic                   access_done,
  input  logic                   trap_take,
  output ctrl_pkg::ctrl_state_t  state,
  output ctrl_pkg::acc_kind_t    acc_kind,
  output logic                   sync_trap
);
  import ctrl_pkg::*;

  ctrl_state_t state_nxt;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= S_FETCH;
    end else if (!stall) begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = S_FETCH;
    case (state)
      S_FETCH: begin
        if (trap_take)        state_nxt = S_TRAP_ENTER;
        else if (access_done) state_nxt = S_DECODE;
        else                  state_nxt = S_FETCH; // wait for mem_ready
      end
      S_DECODE: begin
        case (cls)
          CLS_LOAD, CLS_STORE: state_nxt = S_MEM_ADDR;
          CLS_RTYPE:           state_nxt = S_EXEC_R;
          CLS_ITYPE:           state_nxt = S_EXEC_I;
          CLS_JAL:             state_nxt = S_JAL;
          CLS_JALR:            state_nxt = S_JALR;
          CLS_BRANCH:          state_nxt = S_BRANCH;
          CLS_LUI:             state_nxt = S_LUI;
          CLS_AUIPC:           state_nxt = S_AUIPC;
          CLS_MRET:            state_nxt = S_MRET0;
          default:             state_nxt = S_TRAP_ENTER; // ecall, ebreak, illegal
        endcase
      end
      S_MEM_ADDR: state_nxt = (cls == CLS_STORE) ? S_MEM_WRITE : S_MEM_READ;
      S_MEM_READ: begin
        if (trap_take)        state_nxt = S_TRAP_ENTER;
        else if (access_done) state_nxt = S_MEM_WB;
        else                  state_nxt = S_MEM_READ;
      end
      S_MEM_WB:   state_nxt = S_FETCH;
      S_MEM_WRITE: begin
        if (trap_take)        state_nxt = S_TRAP_ENTER;
        else if (access_done) state_nxt = S_FETCH;
        else                  state_nxt = S_MEM_WRITE;
      end
      S_EXEC_R,
      S_EXEC_I,
      S_LUI,
      S_AUIPC:    state_nxt = S_ALU_WB;
      S_JALR:     state_nxt = S_JAL;   // target computed, then link like jal
      S_JAL:      state_nxt = S_ALU_WB;
      S_ALU_WB:   state_nxt = S_FETCH;
      S_BRANCH:   state_nxt = S_FETCH;
      S_MRET0:    state_nxt = S_MRET1;
      S_MRET1:    state_nxt = S_FETCH;
      S_TRAP_ENTER: state_nxt = S_TRAP_JUMP;
      S_TRAP_JUMP:  state_nxt = S_FETCH;
      default:    state_nxt = S_FETCH;
    endcase
  end

  always_comb begin
    case (state)
      S_FETCH:     acc_kind = ACC_FETCH;
      S_MEM_READ:  acc_kind = ACC_LOAD;
      S_MEM_WRITE: acc_kind = ACC_STORE;
      default:     acc_kind = ACC_NONE;
    endcase
  end

  // cause capture request for traps detected at decode
  assign sync_trap = (state == S_DECODE) &&
                     ((cls == CLS_ILLEGAL) || (cls == CLS_ECALL) || (cls == CLS_EBREAK));

endmodule

// ==== ctrl_outputs.sv ====
// per-state datapath control
// mux selects, alu op and the write/update/retire strobes
module ctrl_outputs (
  input  ctrl_pkg::ctrl_state_t  state,
  input  ctrl_pkg::instr_class_t cls,
  input  logic                   access_done,
  output ctrl_pkg::adr_src_t     adr_src,
  output ctrl_pkg::src_a_t       src_a,
  output ctrl_pkg::src_b_t       src_b,
  output ctrl_pkg::alu_op_t      alu_op,
  output ctrl_pkg::result_src_t  result_src,
  output logic                   store_instr,
  output logic                   pc_update,
  output logic                   branch,
  output logic                   reg_write,
  output logic                   mem_write,
  output logic                   exception_event,
  output logic                   mret,
  output logic                   incr_inst_retired
);
  import ctrl_pkg::*;

  always_comb begin
    adr_src           = ADR_PC;
    src_a             = SRCA_PC;
    src_b             = SRCB_RD2;
    alu_op            = ALU_ADD;
    result_src        = RES_ALUOUT;
    store_instr       = 1'b0;
    pc_update         = 1'b0;
    branch            = 1'b0;
    reg_write         = 1'b0;
    mem_write         = 1'b0;
    exception_event   = 1'b0;
    mret              = 1'b0;
    incr_inst_retired = 1'b0;

    case (state)
      S_FETCH: begin
        // instr <- mem[pc], pc <- pc + 4
        src_b       = SRCB_CONST_4;
        result_src  = RES_ALURESULT;
        store_instr = access_done;
        pc_update   = access_done;
      end
      S_DECODE: begin
        src_a = SRCA_OLD_PC; // aluout <- old_pc + imm
        src_b = SRCB_IMM;
      end
      S_MEM_ADDR: begin
        src_a = SRCA_RD1;
        src_b = SRCB_IMM;
      end
      S_MEM_READ: adr_src = ADR_RESULT;
      S_MEM_WB: begin
        result_src        = RES_DATA;
        reg_write         = 1'b1;
        incr_inst_retired = 1'b1;
      end
      S_MEM_WRITE: begin
        adr_src           = ADR_RESULT;
        mem_write         = (cls == CLS_STORE); // held until the bus accepts
        incr_inst_retired = access_done;
      end
      S_EXEC_R: begin
        src_a  = SRCA_RD1;
        alu_op = ALU_ARITH;
      end
      S_EXEC_I: begin
        src_a  = SRCA_RD1;
        src_b  = SRCB_IMM;
        alu_op = ALU_ARITH;
      end
      S_ALU_WB: begin
        reg_write         = 1'b1;
        incr_inst_retired = 1'b1;
      end
      S_JAL: begin
        src_a     = SRCA_OLD_PC; // link value old_pc + 4
        src_b     = SRCB_CONST_4;
        pc_update = 1'b1;        // pc <- aluout target
      end
      S_JALR: begin
        src_a = SRCA_RD1;
        src_b = SRCB_IMM;
      end
      S_BRANCH: begin
        src_a             = SRCA_RD1;
        alu_op            = ALU_BRANCH;
        branch            = 1'b1;
        incr_inst_retired = 1'b1;
      end
      S_LUI: begin
        src_b  = SRCB_IMM;
        alu_op = ALU_LUI;
      end
      S_AUIPC: begin
        src_a  = SRCA_OLD_PC;
        src_b  = SRCB_IMM;
        alu_op = ALU_AUIPC;
      end
      S_MRET0: mret = 1'b1;
      S_TRAP_ENTER: exception_event = 1'b1; // cause/badaddr already latched
      S_MRET1,
      S_TRAP_JUMP: begin
        pc_update         = 1'b1;
        incr_inst_retired = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== ctrl_pkg.sv ====
// shared types for the multicycle control unit
// datapath selector encodings, opcodes and trap causes
// control state enum
package ctrl_pkg;

  typedef logic [31:0] word_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] cause_t;

  typedef logic [3:0] instr_class_t;
  localparam instr_class_t CLS_LOAD    = 4'd0;
  localparam instr_class_t CLS_STORE   = 4'd1;
  localparam instr_class_t CLS_RTYPE   = 4'd2;
  localparam instr_class_t CLS_ITYPE   = 4'd3;
  localparam instr_class_t CLS_JAL     = 4'd4;
  localparam instr_class_t CLS_JALR    = 4'd5;
  localparam instr_class_t CLS_BRANCH  = 4'd6;
  localparam instr_class_t CLS_LUI     = 4'd7;
  localparam instr_class_t CLS_AUIPC   = 4'd8;
  localparam instr_class_t CLS_MRET    = 4'd9;
  localparam instr_class_t CLS_ECALL   = 4'd10;
  localparam instr_class_t CLS_EBREAK  = 4'd11;
  localparam instr_class_t CLS_ILLEGAL = 4'd12;

  typedef logic [2:0] imm_src_t;
  localparam imm_src_t IMM_R = 3'd0;
  localparam imm_src_t IMM_I = 3'd1;
  localparam imm_src_t IMM_S = 3'd2;
  localparam imm_src_t IMM_B = 3'd3;
  localparam imm_src_t IMM_U = 3'd4;
  localparam imm_src_t IMM_J = 3'd5;

  typedef logic [1:0] src_a_t;
  localparam src_a_t SRCA_PC     = 2'd0;
  localparam src_a_t SRCA_OLD_PC = 2'd1;
  localparam src_a_t SRCA_RD1    = 2'd2;

  typedef logic [1:0] src_b_t;
  localparam src_b_t SRCB_RD2     = 2'd0;
  localparam src_b_t SRCB_IMM     = 2'd1;
  localparam src_b_t SRCB_CONST_4 = 2'd2;

  typedef logic [2:0] alu_op_t;
  localparam alu_op_t ALU_ADD    = 3'd0;
  localparam alu_op_t ALU_ARITH  = 3'd1; // funct3/funct7 decoded in the alu
  localparam alu_op_t ALU_BRANCH = 3'd2;
  localparam alu_op_t ALU_LUI    = 3'd3;
  localparam alu_op_t ALU_AUIPC  = 3'd4;

  typedef logic [1:0] result_src_t;
  localparam result_src_t RES_ALUOUT    = 2'd0;
  localparam result_src_t RES_DATA      = 2'd1;
  localparam result_src_t RES_ALURESULT = 2'd2;

  typedef logic adr_src_t;
  localparam adr_src_t ADR_PC     = 1'b0;
  localparam adr_src_t ADR_RESULT = 1'b1;

  typedef logic [1:0] acc_kind_t;
  localparam acc_kind_t ACC_NONE  = 2'd0;
  localparam acc_kind_t ACC_FETCH = 2'd1;
  localparam acc_kind_t ACC_LOAD  = 2'd2;
  localparam acc_kind_t ACC_STORE = 2'd3;

  // rv32i major opcodes
  localparam opcode_t OP_LOAD   = 7'b000_0011;
  localparam opcode_t OP_STORE  = 7'b010_0011;
  localparam opcode_t OP_RTYPE  = 7'b011_0011;
  localparam opcode_t OP_ITYPE  = 7'b001_0011;
  localparam opcode_t OP_JAL    = 7'b110_1111;
  localparam opcode_t OP_JALR   = 7'b110_0111;
  localparam opcode_t OP_BRANCH = 7'b110_0011;
  localparam opcode_t OP_LUI    = 7'b011_0111;
  localparam opcode_t OP_AUIPC  = 7'b001_0111;
  localparam opcode_t OP_SYSTEM = 7'b111_0011;

  // mcause exception codes
  localparam cause_t EXC_INSTR_MISALIGNED = 32'd0;
  localparam cause_t EXC_INSTR_ACCESS     = 32'd1;
  localparam cause_t EXC_ILLEGAL          = 32'd2;
  localparam cause_t EXC_BREAKPOINT       = 32'd3;
  localparam cause_t EXC_LOAD_MISALIGNED  = 32'd4;
  localparam cause_t EXC_LOAD_ACCESS      = 32'd5;
  localparam cause_t EXC_STORE_MISALIGNED = 32'd6;
  localparam cause_t EXC_STORE_ACCESS     = 32'd7;
  localparam cause_t EXC_ECALL_M          = 32'd11;

  typedef enum logic [4:0] {
    S_FETCH, S_DECODE,
    S_MEM_ADDR, S_MEM_READ, S_MEM_WB, S_MEM_WRITE,
    S_EXEC_R, S_EXEC_I, S_ALU_WB,
    S_JAL, S_JALR, S_BRANCH, S_LUI, S_AUIPC,
    S_MRET0, S_MRET1,
    S_TRAP_ENTER, S_TRAP_JUMP
  } ctrl_state_t;

endpackage

// ==== instr_decoder.sv ====
// instruction classifier
// maps opcode and function fields to an instruction class
// and picks the immediate format for the datapath
module instr_decoder (
  input  ctrl_pkg::opcode_t      op,
  input  ctrl_pkg::funct3_t      funct3,
  input  ctrl_pkg::funct7_t      funct7,
  input  ctrl_pkg::reg_idx_t     rs1,
  input  ctrl_pkg::reg_idx_t     rs2,
  input  ctrl_pkg::reg_idx_t     rd,
  output ctrl_pkg::instr_class_t cls,
  output ctrl_pkg::imm_src_t     imm_src
);
  import ctrl_pkg::*;

  logic load_ok, store_ok, branch_ok, rtype_ok, itype_ok;
  logic sys_base, is_ecall, is_ebreak, is_mret;

  // legal funct3/funct7 combinations per format
  assign load_ok   = (funct3 != 3'd3) && (funct3 != 3'd6) && (funct3 != 3'd7);
  assign store_ok  = (funct3 <= 3'd2);
  assign branch_ok = (funct3 != 3'd2) && (funct3 != 3'd3);
  assign rtype_ok  = (funct7 == 7'h00) ||
                     ((funct7 == 7'h20) && ((funct3 == 3'd0) || (funct3 == 3'd5)));
  assign itype_ok  = (funct3 == 3'd1) ? (funct7 == 7'h00) :
                     (funct3 == 3'd5) ? ((funct7 == 7'h00) || (funct7 == 7'h20)) : 1'b1;

  // system encodings must match exactly
  assign sys_base  = (op == OP_SYSTEM) && (funct3 == 3'd0) && (rs1 == 5'd0) && (rd == 5'd0);
  assign is_ecall  = sys_base && (funct7 == 7'h00) && (rs2 == 5'd0);
  assign is_ebreak = sys_base && (funct7 == 7'h00) && (rs2 == 5'd1);
  assign is_mret   = sys_base && (funct7 == 7'b001_1000) && (rs2 == 5'd2);

  always_comb begin
    cls = CLS_ILLEGAL;
    case (op)
      OP_LOAD:   if (load_ok) cls = CLS_LOAD;
      OP_STORE:  if (store_ok) cls = CLS_STORE;
      OP_RTYPE:  if (rtype_ok) cls = CLS_RTYPE; // mul/div not supported
      OP_ITYPE:  if (itype_ok) cls = CLS_ITYPE;
      OP_JAL:    cls = CLS_JAL;
      OP_JALR:   if (funct3 == 3'd0) cls = CLS_JALR;
      OP_BRANCH: if (branch_ok) cls = CLS_BRANCH;
      OP_LUI:    cls = CLS_LUI;
      OP_AUIPC:  cls = CLS_AUIPC;
      OP_SYSTEM: begin
        if (is_mret)        cls = CLS_MRET;
        else if (is_ecall)  cls = CLS_ECALL;
        else if (is_ebreak) cls = CLS_EBREAK;
      end
      default:   cls = CLS_ILLEGAL;
    endcase
  end

  always_comb begin
    case (cls)
      CLS_RTYPE:              imm_src = IMM_R;
      CLS_STORE:              imm_src = IMM_S;
      CLS_BRANCH:             imm_src = IMM_B;
      CLS_LUI, CLS_AUIPC:     imm_src = IMM_U;
      CLS_JAL:                imm_src = IMM_J;
      default:                imm_src = IMM_I; // load, itype, jalr, system
    endcase
  end

endmodule

// ==== mem_trap_unit.sv ====
// memory request gating and trap capture
// selects the misalignment flag for the current access, raises
// mem_valid and the done/trap handshakes, latches cause and badaddr
module mem_trap_unit (
  input  logic                   clk,
  input  logic                   resetn,
  input  ctrl_pkg::acc_kind_t    acc_kind,
  input  logic                   sync_trap,
  input  ctrl_pkg::instr_class_t cls,
  input  ctrl_pkg::opcode_t      op,
  input  ctrl_pkg::word_t        mem_addr,
  input  logic                   mem_ready,
  input  logic                   access_fault,
  input  logic                   instr_unaligned,
  input  logic                   load_unaligned,
  input  logic                   store_unaligned,
  output logic                   mem_valid,
  output logic                   access_done,
  output logic                   trap_take,
  output ctrl_pkg::cause_t       cause,
  output ctrl_pkg::word_t        badaddr
);
  import ctrl_pkg::*;

  logic   misaligned;
  cause_t mem_cause;
  cause_t sync_cause;
  word_t  sync_badaddr;

  always_comb begin
    misaligned = 1'b0;
    mem_cause  = EXC_INSTR_ACCESS;
    case (acc_kind)
      ACC_FETCH: begin
        misaligned = instr_unaligned;
        mem_cause  = instr_unaligned ? EXC_INSTR_MISALIGNED : EXC_INSTR_ACCESS;
      end
      ACC_LOAD: begin
        misaligned = load_unaligned;
        mem_cause  = load_unaligned ? EXC_LOAD_MISALIGNED : EXC_LOAD_ACCESS;
      end
      ACC_STORE: begin
        misaligned = store_unaligned;
        mem_cause  = store_unaligned ? EXC_STORE_MISALIGNED : EXC_STORE_ACCESS;
      end
      default: ;
    endcase
  end

  // a misaligned access never reaches the bus
  assign mem_valid   = (acc_kind != ACC_NONE) && !misaligned;
  assign access_done = mem_valid && mem_ready && !access_fault;
  assign trap_take   = misaligned || (mem_valid && mem_ready && access_fault);

  always_comb begin
    sync_badaddr = '0;
    case (cls)
      CLS_ECALL:  sync_cause = EXC_ECALL_M;  // machine mode only
      CLS_EBREAK: sync_cause = EXC_BREAKPOINT;
      default: begin
        sync_cause   = EXC_ILLEGAL;
        sync_badaddr = {25'd0, op};          // faulting opcode
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cause   <= '0;
      badaddr <= '0;
    end else if (trap_take) begin
      cause   <= mem_cause;
      badaddr <= mem_addr;
    end else if (sync_trap) begin
      cause   <= sync_cause;
      badaddr <= sync_badaddr;
    end
  end

endmodule

// ==== riscv_ctrl.sv ====
// multicycle rv32i control unit top level
// decoder, sequencer, memory/trap unit and output decode
module riscv_ctrl (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  stall,
  input  ctrl_pkg::opcode_t     op,
  input  ctrl_pkg::funct3_t     funct3,
  input  ctrl_pkg::funct7_t     funct7,
  input  ctrl_pkg::reg_idx_t    rs1,
  input  ctrl_pkg::reg_idx_t    rs2,
  input  ctrl_pkg::reg_idx_t    rd,
  input  ctrl_pkg::word_t       mem_addr,
  input  logic                  mem_ready,
  input  logic                  access_fault,
  input  logic                  instr_unaligned,
  input  logic                  load_unaligned,
  input  logic                  store_unaligned,
  output logic                  mem_valid,
  output ctrl_pkg::cause_t      cause,
  output ctrl_pkg::word_t       badaddr,
  output ctrl_pkg::imm_src_t    imm_src,
  output ctrl_pkg::adr_src_t    adr_src,
  output ctrl_pkg::src_a_t      src_a,
  output ctrl_pkg::src_b_t      src_b,
  output ctrl_pkg::alu_op_t     alu_op,
  output ctrl_pkg::result_src_t result_src,
  output logic                  store_instr,
  output logic                  pc_update,
  output logic                  branch,
  output logic                  reg_write,
  output logic                  mem_write,
  output logic                  exception_event,
  output logic                  mret,
  output logic                  incr_inst_retired
);
  import ctrl_pkg::*;

  instr_class_t cls;
  ctrl_state_t  state;
  acc_kind_t    acc_kind;
  logic         sync_trap;
  logic         access_done;
  logic         trap_take;

  instr_decoder i_decoder (
    .op, .funct3, .funct7, .rs1, .rs2, .rd, .cls, .imm_src
  );

  mem_trap_unit i_mem_trap (
    .clk, .resetn, .acc_kind, .sync_trap, .cls, .op, .mem_addr,
    .mem_ready, .access_fault, .instr_unaligned, .load_unaligned,
    .store_unaligned, .mem_valid, .access_done, .trap_take, .cause, .badaddr
  );

  ctrl_fsm i_fsm (
    .clk, .resetn, .stall, .cls, .access_done, .trap_take,
    .state, .acc_kind, .sync_trap
  );

  ctrl_outputs i_outputs (
    .state, .cls, .access_done, .adr_src, .src_a, .src_b, .alu_op,
    .result_src, .store_instr, .pc_update, .branch, .reg_write,
    .mem_write, .exception_event, .mret, .incr_inst_retired
  );

endmodule

// ==== tb_checks.svh ====
// report helpers and strobe checks for the control unit testbench
// cycle waits with timeout, writeback and trap sequence checks
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  task automatic report_mismatch(input string msg);
    err_count++;
    $display("MISMATCH at time %0t: %s", $time, msg);
  endtask

  task automatic report_failure(input string msg);
    err_count++;
    $display("ERROR at time %0t: %s", $time, msg);
  endtask

  function automatic logic strobe_value(input string name);
    if (name == "retire")         return incr_inst_retired;
    else if (name == "branch")    return branch;
    else if (name == "pc_update") return pc_update;
    else if (name == "exception") return exception_event;
    else if (name == "mret")      return mret;
    else                          return mem_valid;
  endfunction

  // steps one cycle at a time until the named output goes high
  task automatic wait_for(input string name, input int limit, output int cycles);
    cycles = 0;
    do begin
      tick(1'b0, 1'b0);
      cycles++;
    end while (!strobe_value(name) && cycles < limit);
    assert (strobe_value(name))
      else report_failure($sformatf("timed out waiting for %s", name));
  endtask

  // every output in one word, to spot changes under stall
  function automatic logic [31:0] output_word();
    return {10'd0, mem_valid, imm_src, adr_src, src_a, src_b, alu_op, result_src,
            store_instr, pc_update, branch, reg_write, mem_write, exception_event,
            mret, incr_inst_retired};
  endfunction

  task automatic idle_check();
    assert (mem_valid) else report_mismatch("mem_valid low after reset");
    assert ({reg_write, mem_write, pc_update, branch, exception_event, mret,
             incr_inst_retired} == 7'd0)
      else report_mismatch("strobe active after reset");
  endtask

  task automatic writeback_check(input result_src_t exp_res);
    assert (reg_write && incr_inst_retired) else report_mismatch("writeback strobes missing");
    assert (result_src == exp_res)
      else report_mismatch($sformatf("result_src %0d, expected %0d", result_src, exp_res));
  endtask

  // trap entry with cause and badaddr, then the jump cycle
  task automatic trap_check(input cause_t exp_cause, input word_t exp_badaddr);
    assert (exception_event && !pc_update) else report_mismatch("trap entry strobes wrong");
    assert (cause == exp_cause)
      else report_mismatch($sformatf("cause %0d, expected %0d", cause, exp_cause));
    assert (badaddr == exp_badaddr)
      else report_mismatch($sformatf("badaddr %h, expected %h", badaddr, exp_badaddr));
    tick(1'b0, 1'b0);
    assert (pc_update && incr_inst_retired && !exception_event)
      else report_mismatch("trap jump without pc_update or retire");
  endtask

`endif

// ==== tb_riscv_ctrl.sv ====
// testbench for the rv32i control unit
// clock, reset, instruction driver and directed tests
module tb_riscv_ctrl;
  import ctrl_pkg::*;

  logic        clk;
  logic        resetn;
  logic        stall;
  opcode_t     op;
  funct3_t     funct3;
  funct7_t     funct7;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  reg_idx_t    rd;
  word_t       mem_addr;
  logic        mem_ready;
  logic        access_fault;
  logic        instr_unaligned;
  logic        load_unaligned;
  logic        store_unaligned;
  logic        mem_valid;
  cause_t      cause;
  word_t       badaddr;
  imm_src_t    imm_src;
  adr_src_t    adr_src;
  src_a_t      src_a;
  src_b_t      src_b;
  alu_op_t     alu_op;
  result_src_t result_src;
  logic        store_instr, pc_update, branch, reg_write, mem_write;
  logic        exception_event, mret, incr_inst_retired;

  int          err_count;
  int          test_count;
  int          test_errs; // error count when the current test began
  logic [31:0] rng_state;

  riscv_ctrl i_dut (.*);

  `include "tb_checks.svh"

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic reg_idx_t rand_reg();
    return reg_idx_t'(next_rand() % 32);
  endfunction

  // one cycle, inputs change on the falling edge
  task automatic tick(input logic ready, input logic hold);
    @(negedge clk);
    mem_ready = ready;
    stall     = hold;
    #1;
  endtask

  // present an instruction and accept its fetch after delay idle cycles
  task automatic fetch_instr(input word_t instr, input int delay);
    @(negedge clk);
    {funct7, rs2, rs1, funct3, rd, op} = instr;
    {access_fault, instr_unaligned, load_unaligned, store_unaligned} = 4'b0;
    mem_addr  = next_rand();
    mem_ready = 1'b0;
    #1;
    assert (mem_valid && !pc_update) else report_mismatch("no fetch request pending");
    repeat (delay) tick(1'b0, 1'b0);
    tick(1'b1, 1'b0);
    assert (pc_update && store_instr) else report_mismatch("fetch not accepted on mem_ready");
    assert (src_a == SRCA_PC && src_b == SRCB_CONST_4 && result_src == RES_ALURESULT)
      else report_mismatch("fetch does not select pc + 4");
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("test %-16s %0d error(s)", name, err_count - test_errs);
    test_errs = err_count;
  endtask

  task automatic alu_test(input string name, input word_t instr, input imm_src_t exp_imm,
                          input alu_op_t exp_op);
    int n;
    fetch_instr(instr, next_rand() % 4);
    tick(1'b0, 1'b0); // decode
    tick(1'b0, 1'b0); // execute
    assert (alu_op == exp_op && !incr_inst_retired)
      else report_mismatch($sformatf("%s alu_op %0d, expected %0d", name, alu_op, exp_op));
    assert (imm_src == exp_imm)
      else report_mismatch($sformatf("%s imm_src %0d, expected %0d", name, imm_src, exp_imm));
    wait_for("retire", 10, n);
    assert (n == 1)
      else report_mismatch($sformatf("%s retired %0d cycles after fetch, expected 3",
                                     name, n + 2));
    writeback_check(RES_ALUOUT);
    end_test(name);
  endtask

  task automatic load_test(input int delay);
    int n;
    fetch_instr({12'h0, rand_reg(), 3'd2, rand_reg(), OP_LOAD}, 1);
    tick(1'b0, 1'b0); // decode
    tick(1'b0, 1'b0); // address
    assert (!mem_valid) else report_mismatch("mem_valid high in address phase");
    wait_for("mem_valid", 4, n);
    repeat (delay) begin
      assert (adr_src == ADR_RESULT && !reg_write) else report_mismatch("load read outputs wrong");
      tick(1'b0, 1'b0);
    end
    tick(1'b1, 1'b0);
    assert (mem_valid && !reg_write) else report_mismatch("load written back before completion");
    tick(1'b0, 1'b0);
    writeback_check(RES_DATA);
    end_test("load");
  endtask

  task automatic store_test(input int delay);
    int n;
    fetch_instr({7'h0, rand_reg(), rand_reg(), 3'd2, 5'h0, OP_STORE}, 0);
    tick(1'b0, 1'b0);
    tick(1'b0, 1'b0);
    wait_for("mem_valid", 4, n);
    repeat (delay) begin
      assert (mem_write && !incr_inst_retired)
        else report_mismatch("store mem_write dropped or retired early");
      tick(1'b0, 1'b0);
    end
    tick(1'b1, 1'b0);
    assert (mem_write && incr_inst_retired) else report_mismatch("store not retired on mem_ready");
    end_test("store");
  endtask

  // branch and jumps, strobe distance from the accepted fetch
  task automatic flow_test(input string name, input word_t instr, input string strobe,
                           input int exp_n);
    int n;
    fetch_instr(instr, next_rand() % 4);
    wait_for(strobe, 10, n);
    assert (n == exp_n)
      else report_mismatch($sformatf("%s %s after %0d cycles, expected %0d",
                                     name, strobe, n, exp_n));
    if (strobe == "branch") begin
      assert (incr_inst_retired) else report_mismatch("branch not retired with its strobe");
    end else begin
      tick(1'b0, 1'b0);
      writeback_check(RES_ALUOUT);
    end
    end_test(name);
  endtask

  // mret strobe after decode, then the pc update cycle
  task automatic mret_test();
    int n;
    fetch_instr(32'h3020_0073, 0);
    wait_for("mret", 10, n);
    assert (n == 2) else report_mismatch($sformatf("mret after %0d cycles, expected 2", n));
    tick(1'b0, 1'b0);
    assert (pc_update && incr_inst_retired && !mret)
      else report_mismatch("mret without pc_update or retire");
    end_test("mret");
  endtask

  task automatic sync_trap_test(input string name, input word_t instr, input cause_t exp_cause,
                                input word_t exp_badaddr);
    int n;
    fetch_instr(instr, 0);
    wait_for("exception", 10, n);
    assert (n == 2) else report_mismatch($sformatf("%s trap entry after %0d cycles", name, n));
    trap_check(exp_cause, exp_badaddr);
    end_test(name);
  endtask

  task automatic misaligned_load_test();
    int n;
    fetch_instr({12'h0, rand_reg(), 3'd2, rand_reg(), OP_LOAD}, 0);
    @(negedge clk); // decode
    load_unaligned = 1'b1;
    mem_ready      = 1'b0;
    #1;
    tick(1'b0, 1'b0); // address
    tick(1'b0, 1'b0); // read phase with the request suppressed
    assert (!mem_valid && adr_src == ADR_RESULT) else report_mismatch("misaligned load on the bus");
    wait_for("exception", 4, n);
    trap_check(EXC_LOAD_MISALIGNED, mem_addr);
    end_test("load_misaligned");
  endtask

  task automatic faulting_store_test();
    int n;
    fetch_instr({7'h0, rand_reg(), rand_reg(), 3'd2, 5'h0, OP_STORE}, 0);
    tick(1'b0, 1'b0);
    tick(1'b0, 1'b0);
    wait_for("mem_valid", 4, n);
    @(negedge clk);
    access_fault = 1'b1; // bus answers with an error
    mem_ready    = 1'b1;
    #1;
    assert (mem_write && !incr_inst_retired) else report_mismatch("faulting store retired");
    wait_for("exception", 4, n);
    trap_check(EXC_STORE_ACCESS, mem_addr);
    end_test("store_fault");
  endtask

  task automatic stall_test(input int k);
    int          n;
    logic [31:0] snap;
    fetch_instr({7'h0, rand_reg(), rand_reg(), 3'd0, rand_reg(), OP_RTYPE}, 0);
    tick(1'b0, 1'b0); // decode
    tick(1'b0, 1'b1); // execute, held from here
    snap = output_word();
    repeat (k - 1) begin
      tick(1'b0, 1'b1);
      assert (output_word() == snap) else report_mismatch("outputs changed while stalled");
    end
    tick(1'b0, 1'b0);
    assert (output_word() == snap) else report_mismatch("outputs changed on stall release");
    wait_for("retire", 10, n);
    assert (n == 1)
      else report_mismatch($sformatf("retire after %0d cycles with %0d stalled, expected %0d",
                                     k + 2 + n, k, k + 3));
    writeback_check(RES_ALUOUT);
    end_test("stall");
  endtask

  initial begin
    rng_state  = 32'd35364;
    err_count  = 0;
    test_count = 0;
    test_errs  = 0;
    resetn     = 1'b0;
    stall      = 1'b0;
    mem_addr   = '0;
    mem_ready  = 1'b0;
    {funct7, rs2, rs1, funct3, rd, op} = 32'h0;
    {access_fault, instr_unaligned, load_unaligned, store_unaligned} = 4'b0;
    repeat (4) @(negedge clk);
    resetn = 1'b1;
    #1;
    idle_check();
    end_test("reset");

    alu_test("rtype", {7'h00, rand_reg(), rand_reg(), 3'd0, rand_reg(), OP_RTYPE}, IMM_R,
             ALU_ARITH);
    alu_test("itype", {7'h00, rand_reg(), rand_reg(), 3'd0, rand_reg(), OP_ITYPE}, IMM_I,
             ALU_ARITH);
    alu_test("lui", {rand_reg(), rand_reg(), rand_reg(), rand_reg(), rand_reg(), OP_LUI},
             IMM_U, ALU_LUI);
    alu_test("auipc", {rand_reg(), rand_reg(), rand_reg(), rand_reg(), rand_reg(), OP_AUIPC},
             IMM_U, ALU_AUIPC);
    load_test(1 + next_rand() % 4);
    store_test(1 + next_rand() % 4);
    flow_test("branch", {7'h00, rand_reg(), rand_reg(), 3'd0, 5'd0, OP_BRANCH}, "branch", 2);
    flow_test("jal", {rand_reg(), rand_reg(), rand_reg(), rand_reg(), rand_reg(), OP_JAL},
              "pc_update", 2);
    flow_test("jalr", {12'h0, rand_reg(), 3'd0, rand_reg(), OP_JALR}, "pc_update", 3);
    mret_test();
    sync_trap_test("illegal", {25'd0, 7'h2b}, EXC_ILLEGAL, {25'd0, 7'h2b});
    sync_trap_test("ecall", 32'h0000_0073, EXC_ECALL_M, 32'h0);
    sync_trap_test("ebreak", 32'h0010_0073, EXC_BREAKPOINT, 32'h0);
    misaligned_load_test();
    faulting_store_test();
    stall_test(1 + next_rand() % 4);

    $display("%0d tests run, %0d errors", test_count, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+.
ctrl_pkg.sv
instr_decoder.sv
mem_trap_unit.sv
ctrl_fsm.sv
ctrl_outputs.sv
riscv_ctrl.sv
tb_riscv_ctrl.sv
